/* Makefile */
TOP := tb_mips_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
hw/mips_pkg.sv
hw/rf_read_if.sv
hw/fetch_stage.sv
hw/inst_decode.sv
hw/regfile.sv
hw/id_ex_reg.sv
hw/execute.sv
hw/mips_core.sv
sim/mips_core_props.sv
sim/tb_mips_core.sv

/* hw/execute.sv */
`default_nettype none

module execute import mips_pkg::*; (
	input  wire                   clk,
	input  wire                   reset_i,
	input  wire [ALUOP_W-1:0]     aluop_i,
	input  wire [ALUSEL_W-1:0]    alusel_i,
	input  wire [REG_W-1:0]       opnd1_i,
	input  wire [REG_W-1:0]       opnd2_i,
	input  wire [REG_ADDR_W-1:0]  wd_i,
	input  wire                   wreg_i,
	output logic                  fwd_we_o,
	output logic [REG_ADDR_W-1:0] fwd_addr_o,
	output logic [REG_W-1:0]      fwd_data_o,
	output logic                  wb_we_o,
	output logic [REG_ADDR_W-1:0] wb_addr_o,
	output logic [REG_W-1:0]      wb_data_o
);

	logic [REG_W-1:0] logic_res;
	logic [REG_W-1:0] result;

	always_comb begin
		case (aluop_i)
			ALUOP_OR:  logic_res = opnd1_i | opnd2_i;
			ALUOP_AND: logic_res = opnd1_i & opnd2_i;
			ALUOP_XOR: logic_res = opnd1_i ^ opnd2_i;
			default:   logic_res = '0;
		endcase
	end

	always_comb begin
		case (alusel_i)
			RES_LOGIC: result = logic_res;
			default:   result = '0;
		endcase
	end

	// Decode picks this up for the instruction directly behind.
	assign fwd_we_o   = wreg_i;
	assign fwd_addr_o = wd_i;
	assign fwd_data_o = result;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_we_o   <= 1'b0;
			wb_addr_o <= '0;
			wb_data_o <= '0;
		end else begin
			wb_we_o   <= wreg_i;
			wb_addr_o <= wd_i;
			wb_data_o <= result;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`default_nettype none

module fetch_stage import mips_pkg::*; #(
	parameter logic [REG_W-1:0] RESET_PC = '0
) (
	input  wire              clk,
	input  wire              reset_i,
	input  wire [REG_W-1:0]  inst_i,
	output logic [REG_W-1:0] inst_addr_o,
	output logic             inst_ce_o,
	output inst_t            ifid_inst_o
);

	logic [REG_W-1:0] pc;

	always_ff @(posedge clk) begin
		inst_ce_o <= !reset_i; // Enabled from the first cycle after reset.
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc <= RESET_PC;
		end else if (inst_ce_o) begin
			pc <= pc + 32'd4;
		end
	end

	assign inst_addr_o = pc;

	// An all-zero word decodes as NOP.
	always_ff @(posedge clk) begin
		if (reset_i || !inst_ce_o) begin
			ifid_inst_o <= '0;
		end else begin
			ifid_inst_o <= inst_i;
		end
	end

endmodule

`default_nettype wire

/* hw/id_ex_reg.sv */
`default_nettype none

module id_ex_reg import mips_pkg::*; (
	input  wire                   clk,
	input  wire                   reset_i,
	input  wire [ALUOP_W-1:0]     aluop_i,
	input  wire [ALUSEL_W-1:0]    alusel_i,
	input  wire [REG_W-1:0]       opnd1_i,
	input  wire [REG_W-1:0]       opnd2_i,
	input  wire [REG_ADDR_W-1:0]  wd_i,
	input  wire                   wreg_i,
	output logic [ALUOP_W-1:0]    aluop_o,
	output logic [ALUSEL_W-1:0]   alusel_o,
	output logic [REG_W-1:0]      opnd1_o,
	output logic [REG_W-1:0]      opnd2_o,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			aluop_o  <= ALUOP_NOP; // Holds a NOP that writes nothing.
			alusel_o <= RES_NOP;
			opnd1_o  <= '0;
			opnd2_o  <= '0;
			wd_o     <= '0;
			wreg_o   <= 1'b0;
		end else begin
			aluop_o  <= aluop_i;
			alusel_o <= alusel_i;
			opnd1_o  <= opnd1_i;
			opnd2_o  <= opnd2_i;
			wd_o     <= wd_i;
			wreg_o   <= wreg_i;
		end
	end

endmodule

`default_nettype wire

/* hw/inst_decode.sv */
`default_nettype none

module inst_decode import mips_pkg::*; (
	input  wire inst_t             ifid_inst_i,
	rf_read_if.decoder             rf,
	input  wire                    ex_we_i,
	input  wire [REG_ADDR_W-1:0]   ex_addr_i,
	input  wire [REG_W-1:0]        ex_data_i,
	output logic [ALUOP_W-1:0]     aluop_o,
	output logic [ALUSEL_W-1:0]    alusel_o,
	output logic [REG_W-1:0]       opnd1_o,
	output logic [REG_W-1:0]       opnd2_o,
	output logic [REG_ADDR_W-1:0]  wd_o,
	output logic                   wreg_o
);

	logic [REG_W-1:0] imm;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		aluop_o  = ALUOP_NOP;
		alusel_o = RES_NOP;
		wd_o     = '0;
		wreg_o   = 1'b0;
		rf.re1   = 1'b0;
		rf.re2   = 1'b0;
		rf.addr1 = ifid_inst_i.i.rs;
		rf.addr2 = ifid_inst_i.i.rt;
		imm      = '0;

		case (ifid_inst_i.i.op)
			OP_SPECIAL: begin
				case (ifid_inst_i.r.funct)
					FN_OR:   aluop_o = ALUOP_OR;
					FN_AND:  aluop_o = ALUOP_AND;
					FN_XOR:  aluop_o = ALUOP_XOR;
					default: aluop_o = ALUOP_NOP; // Covers NOP itself.
				endcase
				if (aluop_o != ALUOP_NOP) begin
					alusel_o = RES_LOGIC;
					wreg_o   = 1'b1;
					wd_o     = ifid_inst_i.r.rd;
					rf.re1   = 1'b1;
					rf.re2   = 1'b1;
				end
			end
			OP_ORI, OP_ANDI, OP_XORI: begin
				case (ifid_inst_i.i.op)
					OP_ORI:  aluop_o = ALUOP_OR;
					OP_ANDI: aluop_o = ALUOP_AND;
					default: aluop_o = ALUOP_XOR;
				endcase
				alusel_o = RES_LOGIC;
				wreg_o   = 1'b1;
				wd_o     = ifid_inst_i.i.rt;
				rf.re1   = 1'b1;
				imm      = {16'h0, ifid_inst_i.i.imm16};
			end
			OP_LUI: begin
				// LUI is an OR of the shifted immediate with register zero.
				aluop_o  = ALUOP_OR;
				alusel_o = RES_LOGIC;
				wreg_o   = 1'b1;
				wd_o     = ifid_inst_i.i.rt;
				rf.re1   = 1'b1;
				rf.addr1 = '0;
				imm      = {ifid_inst_i.i.imm16, 16'h0};
			end
			default: begin
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operands
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The register file already bypasses its own write port.
	function automatic logic [REG_W-1:0] pick_operand(
		input logic                  re,
		input logic [REG_ADDR_W-1:0] addr,
		input logic [REG_W-1:0]      rf_data
	);
		logic [REG_W-1:0] value;
		if (!re) begin
			value = imm;
		end else if (addr == '0) begin
			value = '0;
		end else if (ex_we_i && ex_addr_i == addr) begin
			value = ex_data_i; // Result of the instruction one ahead.
		end else begin
			value = rf_data;
		end
		return value;
	endfunction

	always_comb begin
		opnd1_o = pick_operand(rf.re1, rf.addr1, rf.data1);
		opnd2_o = pick_operand(rf.re2, rf.addr2, rf.data2);
	end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`default_nettype none

module mips_core import mips_pkg::*; #(
	parameter logic [REG_W-1:0] RESET_PC = '0
) (
	input  wire                   clk,
	input  wire                   reset_i,
	output logic [REG_W-1:0]      inst_addr_o,
	output logic                  inst_ce_o,
	input  wire [REG_W-1:0]       inst_i,
	output logic                  wb_we_o,
	output logic [REG_ADDR_W-1:0] wb_addr_o,
	output logic [REG_W-1:0]      wb_data_o
);

	inst_t                 ifid_inst;

	logic [ALUOP_W-1:0]    id_aluop;
	logic [ALUSEL_W-1:0]   id_alusel;
	logic [REG_W-1:0]      id_opnd1;
	logic [REG_W-1:0]      id_opnd2;
	logic [REG_ADDR_W-1:0] id_wd;
	logic                  id_wreg;

	logic [ALUOP_W-1:0]    ex_aluop;
	logic [ALUSEL_W-1:0]   ex_alusel;
	logic [REG_W-1:0]      ex_opnd1;
	logic [REG_W-1:0]      ex_opnd2;
	logic [REG_ADDR_W-1:0] ex_wd;
	logic                  ex_wreg;

	logic                  fwd_we;
	logic [REG_ADDR_W-1:0] fwd_addr;
	logic [REG_W-1:0]      fwd_data;

	rf_read_if u_rf_if ();

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch_stage (
		.clk         (clk),
		.reset_i     (reset_i),
		.inst_i      (inst_i),
		.inst_addr_o (inst_addr_o),
		.inst_ce_o   (inst_ce_o),
		.ifid_inst_o (ifid_inst)
	);

	inst_decode u_inst_decode (
		.ifid_inst_i (ifid_inst),
		.rf          (u_rf_if),
		.ex_we_i     (fwd_we),
		.ex_addr_i   (fwd_addr),
		.ex_data_i   (fwd_data),
		.aluop_o     (id_aluop),
		.alusel_o    (id_alusel),
		.opnd1_o     (id_opnd1),
		.opnd2_o     (id_opnd2),
		.wd_o        (id_wd),
		.wreg_o      (id_wreg)
	);

	// The write port runs off the EX/WB register, as do the wb outputs.
	regfile u_regfile (
		.clk     (clk),
		.reset_i (reset_i),
		.rf      (u_rf_if),
		.we_i    (wb_we_o),
		.waddr_i (wb_addr_o),
		.wdata_i (wb_data_o)
	);

	id_ex_reg u_id_ex_reg (
		.clk      (clk),
		.reset_i  (reset_i),
		.aluop_i  (id_aluop),
		.alusel_i (id_alusel),
		.opnd1_i  (id_opnd1),
		.opnd2_i  (id_opnd2),
		.wd_i     (id_wd),
		.wreg_i   (id_wreg),
		.aluop_o  (ex_aluop),
		.alusel_o (ex_alusel),
		.opnd1_o  (ex_opnd1),
		.opnd2_o  (ex_opnd2),
		.wd_o     (ex_wd),
		.wreg_o   (ex_wreg)
	);

	execute u_execute (
		.clk        (clk),
		.reset_i    (reset_i),
		.aluop_i    (ex_aluop),
		.alusel_i   (ex_alusel),
		.opnd1_i    (ex_opnd1),
		.opnd2_i    (ex_opnd2),
		.wd_i       (ex_wd),
		.wreg_i     (ex_wreg),
		.fwd_we_o   (fwd_we),
		.fwd_addr_o (fwd_addr),
		.fwd_data_o (fwd_data),
		.wb_we_o    (wb_we_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int REG_W      = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALUOP_W    = 8;
	localparam int ALUSEL_W   = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	localparam logic [5:0] FN_AND = 6'b100100; // All three live under SPECIAL.
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;

	localparam logic [ALUOP_W-1:0] ALUOP_NOP = 8'b00000000;
	localparam logic [ALUOP_W-1:0] ALUOP_AND = 8'b00100100;
	localparam logic [ALUOP_W-1:0] ALUOP_OR  = 8'b00100101;
	localparam logic [ALUOP_W-1:0] ALUOP_XOR = 8'b00100110;

	localparam logic [ALUSEL_W-1:0] RES_NOP   = 3'b000;
	localparam logic [ALUSEL_W-1:0] RES_LOGIC = 3'b001;

	// The same word seen as an immediate format or as a register format.
	typedef union packed {
		struct packed {
			logic [5:0]            op;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [15:0]           imm16;
		} i;
		struct packed {
			logic [5:0]            op;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [REG_ADDR_W-1:0] rd;
			logic [4:0]            shamt;
			logic [5:0]            funct;
		} r;
	} inst_t;

endpackage

`default_nettype wire

/* hw/regfile.sv */
`default_nettype none

module regfile import mips_pkg::*; (
	input  wire                  clk,
	input  wire                  reset_i,
	rf_read_if.regfile           rf,
	input  wire                  we_i,
	input  wire [REG_ADDR_W-1:0] waddr_i,
	input  wire [REG_W-1:0]      wdata_i
);

	// Register zero has no storage.
	logic [REG_W-1:0] regs [1:2**REG_ADDR_W-1];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	function automatic logic [REG_W-1:0] read_port(
		input logic                  re,
		input logic [REG_ADDR_W-1:0] addr
	);
		logic [REG_W-1:0] data;
		data = '0;
		if (re && addr != '0) begin
			if (we_i && waddr_i == addr) begin
				data = wdata_i; // Same-cycle write shows through.
			end else begin
				data = regs[addr];
			end
		end
		return data;
	endfunction

	always_comb begin
		rf.data1 = read_port(rf.re1, rf.addr1);
		rf.data2 = read_port(rf.re2, rf.addr2);
	end

endmodule

`default_nettype wire

/* hw/rf_read_if.sv */
`default_nettype none

interface rf_read_if import mips_pkg::*; ();

	logic                  re1;
	logic [REG_ADDR_W-1:0] addr1;
	logic [REG_W-1:0]      data1;

	logic                  re2;
	logic [REG_ADDR_W-1:0] addr2;
	logic [REG_W-1:0]      data2;

	modport decoder (output re1, addr1, re2, addr2, input data1, data2);

	modport regfile (input re1, addr1, re2, addr2, output data1, data2);

endinterface

`default_nettype wire

/* sim/mips_core_props.sv */
`default_nettype none

module mips_core_props import mips_pkg::*; #(
	parameter logic [REG_W-1:0] RESET_PC = '0
) (
	input wire             clk,
	input wire             reset_i,
	input wire [REG_W-1:0] inst_addr_i,
	input wire             inst_ce_i,
	input wire             wb_we_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0; // Read by the testbench.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fetch control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	quiet_in_reset: assert property (@(posedge clk) reset_i |=> !inst_ce_i && !wb_we_i)
		else begin
			fail_count = fail_count + 1;
			$error("Fetch enable or write-back active during reset.");
		end

	first_fetch_addr: assert property (@(posedge clk) disable iff (reset_i)
		$rose(inst_ce_i) |-> inst_addr_i == RESET_PC)
		else begin
			fail_count = fail_count + 1;
			$error("First fetch is not at the reset address.");
		end

	// Once running, the core fetches every cycle from the next word.
	steady_fetch: assert property (@(posedge clk) disable iff (reset_i)
		inst_ce_i |=> inst_ce_i && inst_addr_i == $past(inst_addr_i) + 32'd4)
		else begin
			fail_count = fail_count + 1;
			$error("Fetch address did not advance by one word.");
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write-back control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	wb_after_fetch: assert property (@(posedge clk) disable iff (reset_i)
		wb_we_i |-> $past(inst_ce_i, 3))
		else begin
			fail_count = fail_count + 1;
			$error("Write-back without a fetch three cycles earlier.");
		end

endmodule

bind mips_core mips_core_props #(
	.RESET_PC (RESET_PC)
) u_props (
	.clk         (clk),
	.reset_i     (reset_i),
	.inst_addr_i (inst_addr_o),
	.inst_ce_i   (inst_ce_o),
	.wb_we_i     (wb_we_o)
);

`default_nettype wire

/* sim/tb_mips_core.sv */
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int               CLK_PERIOD  = 8;
	localparam int               ROM_WORDS   = 64;
	localparam int               LAST_SLOT   = ROM_WORDS + 2;
	localparam int               WATCHDOG_NS = (ROM_WORDS + 16) * CLK_PERIOD * 2;
	localparam logic [REG_W-1:0] RESET_PC    = 32'h0000_1000;

	// MIPS32 opcode and funct encodings.
	localparam logic [5:0] ENC_SPECIAL = 6'h00;
	localparam logic [5:0] ENC_ANDI    = 6'h0c;
	localparam logic [5:0] ENC_ORI     = 6'h0d;
	localparam logic [5:0] ENC_XORI    = 6'h0e;
	localparam logic [5:0] ENC_LUI     = 6'h0f;
	localparam logic [5:0] ENC_FN_ADD  = 6'h20; // Valid MIPS, but not in this core.
	localparam logic [5:0] ENC_FN_AND  = 6'h24;
	localparam logic [5:0] ENC_FN_OR   = 6'h25;
	localparam logic [5:0] ENC_FN_XOR  = 6'h26;

	typedef struct {
		int                    slot;
		logic [REG_ADDR_W-1:0] addr;
		logic [REG_W-1:0]      data;
	} wb_exp_t;

	logic                  clk;
	logic                  reset_i;
	logic [REG_W-1:0]      inst_i = '0;
	logic [REG_W-1:0]      inst_addr_o;
	logic                  inst_ce_o;
	logic                  wb_we_o;
	logic [REG_ADDR_W-1:0] wb_addr_o;
	logic [REG_W-1:0]      wb_data_o;

	logic [REG_W-1:0] rom [ROM_WORDS];
	logic [REG_W-1:0] ref_regs [32];
	logic [31:0]      lfsr_state = 32'h159ba244;
	logic [31:0]      fetch_idx;
	wb_exp_t          exp_q [$];
	int               now_cyc = -1; // Cycles since the first fetch.

	mips_core #(
		.RESET_PC (RESET_PC)
	) u_mips_core (
		.clk         (clk),
		.reset_i     (reset_i),
		.inst_addr_o (inst_addr_o),
		.inst_ce_o   (inst_ce_o),
		.inst_i      (inst_i),
		.wb_we_o     (wb_we_o),
		.wb_addr_o   (wb_addr_o),
		.wb_data_o   (wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
		abort_run("Write-back value mismatch.");
	endtask

	// Random program over registers 0 to 7, run through the reference model in order.
	task automatic build_program();
		logic [31:0] kind;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] rd;
		logic [31:0] imm;
		logic [31:0] pick;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [5:0]  code;
		logic        writes;
		logic [4:0]  dest;
		wb_exp_t     e;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		for (int i = 0; i < ROM_WORDS; i++) begin
			draw_bits(3, kind);
			draw_bits(3, rs);
			draw_bits(3, rt);
			draw_bits(3, rd);
			draw_bits(16, imm);
			draw_bits(2, pick);
			a = ref_regs[rs[4:0]];
			b = ref_regs[rt[4:0]];
			writes = 1'b1;
			dest = rt[4:0];
			res = '0;
			case (kind)
				0: begin
					rom[i] = {ENC_ORI, rs[4:0], rt[4:0], imm[15:0]};
					res = a | {16'h0, imm[15:0]};
				end
				1: begin
					rom[i] = {ENC_ANDI, rs[4:0], rt[4:0], imm[15:0]};
					res = a & {16'h0, imm[15:0]};
				end
				2: begin
					rom[i] = {ENC_XORI, rs[4:0], rt[4:0], imm[15:0]};
					res = a ^ {16'h0, imm[15:0]};
				end
				3: begin
					rom[i] = {ENC_LUI, rs[4:0], rt[4:0], imm[15:0]}; // LUI ignores rs.
					res = {imm[15:0], 16'h0};
				end
				4, 5: begin
					case (pick)
						0: begin
							code = ENC_FN_OR;
							res = a | b;
						end
						1: begin
							code = ENC_FN_AND;
							res = a & b;
						end
						2: begin
							code = ENC_FN_XOR;
							res = a ^ b;
						end
						default: begin
							code = ENC_FN_ADD;
							writes = 1'b0;
						end
					endcase
					rom[i] = {ENC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'h0, code};
					dest = rd[4:0];
				end
				6: begin
					case (pick)
						0: code = 6'h08;         // ADDI
						1: code = 6'h23;         // LW
						2: code = 6'h04;         // BEQ
						default: code = 6'h0a;   // SLTI
					endcase
					rom[i] = {code, rs[4:0], rt[4:0], imm[15:0]};
					writes = 1'b0;
				end
				default: begin
					rom[i] = '0;
					writes = 1'b0;
				end
			endcase
			if (writes) begin
				e.slot = i + 3;
				e.addr = dest;
				e.data = res;
				exp_q.push_back(e);
				if (dest != '0) begin
					ref_regs[dest] = res;
				end
			end
		end
	endtask

	// A write-back is due exactly in its slot, and nowhere else.
	task automatic check_writeback();
		wb_exp_t e;
		assert (u_mips_core.u_props.fail_count == 0)
			else abort_run("A control timing property failed.");
		if (exp_q.size() != 0 && exp_q[0].slot == now_cyc) begin
			e = exp_q.pop_front();
			assert (wb_we_o === 1'b1)
				else report_mismatch("wb_we_o", 32'(wb_we_o), 32'd1);
			assert (wb_addr_o === e.addr)
				else report_mismatch("wb_addr_o", 32'(wb_addr_o), 32'(e.addr));
			assert (wb_data_o === e.data)
				else report_mismatch("wb_data_o", wb_data_o, e.data);
		end else begin
			assert (wb_we_o === 1'b0)
				else report_mismatch("wb_we_o", 32'(wb_we_o), 32'd0);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign fetch_idx = (inst_addr_o - RESET_PC) >> 2;

	// The ROM word is ready well before the rising edge that fetches it.
	always @(negedge clk) begin
		if (inst_ce_o && fetch_idx < ROM_WORDS) begin
			inst_i <= rom[fetch_idx[5:0]];
		end else begin
			inst_i <= '0;
		end
	end

	always @(negedge clk) begin
		if (!reset_i && (inst_ce_o || now_cyc >= 0)) begin
			now_cyc = now_cyc + 1;
			check_writeback();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before the last write-back.");
	end

	initial begin
		reset_i = 1'b1;
		build_program();
		repeat (2) @(negedge clk);
		reset_i = 1'b0;
		while (now_cyc <= LAST_SLOT + 2) begin
			@(posedge clk);
		end
		if (exp_q.size() == 0 && u_mips_core.u_props.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("Write-backs still pending or a control property failed.");
		end
	end

endmodule

`default_nettype wire
